/* cpu_top.f */
+incdir+include
hw/cpu_pkg.sv
hw/prog_mem.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/alu.sv
hw/execute_stage.sv
hw/cpu_top.sv
tb/tb_cpu_top.sv

/* Makefile */
TOP = tb_cpu_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cpu_top.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module cpu_top -f cpu_top.f

clean:
	rm -rf obj_dir sim.log

/* tb/tb_cpu_top.sv */
// Testbench for the pipelined CPU
// Program loader, xorshift operands, reference model and checks
// Nibble loads, ALU ops, IN, halt stability and ignored opcodes

`timescale 1ns/1ns
`include "cpu_defs.svh"

module tb_cpu_top;

  import cpu_pkg::*;

  localparam int RUN_CYCLES      = 3 * `CPU_MEM_DEPTH;  // Three passes of the program
  localparam int PROG_CYCLES     = `CPU_MEM_DEPTH + RUN_CYCLES + 8;
  localparam int WATCHDOG_CYCLES = 10 + 9 * PROG_CYCLES + 100;  // Nine programs

  logic                   clk;
  logic                   rst_n;
  host_ctrl_t             host_ctrl;
  logic [`CPU_DATA_W-1:0] data_in;
  logic [`CPU_DATA_W-1:0] data_out;
  logic [`CPU_DATA_W-1:0] prog [`CPU_MEM_DEPTH];
  int                     prog_len;
  logic [31:0]            rng_state;
  logic [1:0]             low_cnt;  // Edges since run fell, saturating

  cpu_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_ctrl (host_ctrl),
    .data_in   (data_in),
    .data_out  (data_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $fatal(1, "Timeout");
  end

  //////////////////////////////////////////////////
  // Halt check
  //////////////////////////////////////////////////

  // Two edges after run falls the pipeline has drained
  always @(posedge clk) begin
    if (!rst_n || host_ctrl.run) low_cnt <= '0;
    else if (low_cnt != 2'd2) low_cnt <= low_cnt + 1'b1;
  end

  a_halt_stable: assert property (@(posedge clk) disable iff (!rst_n)
    low_cnt == 2'd2 |=> $stable(data_out))
    else report_fail("data_out changed while the CPU was halted");

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic rand_byte(output logic [`CPU_DATA_W-1:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state[15:8];
  endtask

  // Expected C, arithmetic modulo 256
  function automatic logic [`CPU_DATA_W-1:0] model_alu(input logic [`CPU_OPC_W-1:0] opc,
                                                       input int a, input int b);
    int r;
    case (opc)
      `CPU_OP_ADD: r = a + b;
      `CPU_OP_SUB: r = a - b + 256;  // Keeps r positive
      default:     r = a * b;
    endcase
    return 8'(r % 256);
  endfunction

  task automatic new_program();
    prog_len = 0;
    for (int i = 0; i < `CPU_MEM_DEPTH; i++) prog[i] = '0;  // NOP fill
  endtask

  task automatic emit(input logic [`CPU_OPC_W-1:0] opc, input logic [3:0] operand);
    prog[prog_len] = {opc, operand};
    prog_len++;
  endtask

  // Register index 0 A, 1 B, 2 C
  task automatic emit_load(input logic [1:0] r, input logic [`CPU_DATA_W-1:0] v);
    emit(`CPU_OP_LDAL + {r, 1'b0}, v[3:0]);
    emit(`CPU_OP_LDAH + {r, 1'b0}, v[7:4]);
  endtask

  // Load all 16 bytes, run three passes, halt and let the pipeline drain
  task automatic run_program(input logic [`CPU_DATA_W-1:0] in_val);
    for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
      @(posedge clk);
      host_ctrl <= '{run: 1'b0, load: 1'b1, addr: i[`CPU_ADDR_W-1:0]};
      data_in   <= prog[i];
    end
    @(posedge clk);
    host_ctrl <= '{run: 1'b1, load: 1'b0, addr: '0};
    data_in   <= in_val;  // Held for IN during the run
    repeat (RUN_CYCLES) @(posedge clk);
    host_ctrl <= '{run: 1'b0, load: 1'b0, addr: '0};
    repeat (3) @(posedge clk);
  endtask

  task automatic check_out(input logic [`CPU_DATA_W-1:0] exp, input string what);
    @(negedge clk);
    assert (data_out === exp)
      else report_fail($sformatf("%s, data_out 0x%02h, expected 0x%02h", what, data_out, exp));
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [`CPU_DATA_W-1:0] va;
    logic [`CPU_DATA_W-1:0] vb;
    logic [`CPU_DATA_W-1:0] vin;
    logic [`CPU_OPC_W-1:0]  alu_ops [3];
    logic [`CPU_DATA_W-1:0] nib_vals [3];
    rst_n     = 1'b0;
    host_ctrl = '0;
    data_in   = '0;
    rng_state = 32'd45935;
    alu_ops   = '{`CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_MUL};
    nib_vals  = '{8'hA5, 8'h3C, 8'hE7};
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_out(8'h00, "data_out after reset");

    for (int r = 0; r < 3; r++) begin
      new_program();
      emit_load(r[1:0], nib_vals[r]);
      emit(`CPU_OP_OUT, r[3:0]);
      run_program(8'h00);
      check_out(nib_vals[r], $sformatf("nibble load of register %0d", r));
    end

    for (int i = 0; i < 3; i++) begin
      rand_byte(va);
      rand_byte(vb);
      new_program();
      emit_load(2'd0, va);
      emit_load(2'd1, vb);
      emit(alu_ops[i], 4'd0);
      emit(`CPU_OP_OUT, 4'd2);
      run_program(8'h00);
      check_out(model_alu(alu_ops[i], va, vb),
                $sformatf("ALU opcode %0d on 0x%02h and 0x%02h", alu_ops[i], va, vb));
    end

    rand_byte(vin);
    new_program();
    emit(`CPU_OP_IN, 4'd1);
    emit(`CPU_OP_OUT, 4'd1);
    run_program(vin);
    check_out(vin, "IN 1 then OUT 1");

    // Opcodes 0xC to 0xF and IN or OUT with no register
    rand_byte(va);
    rand_byte(vb);
    rand_byte(vin);
    new_program();
    emit_load(2'd0, va);
    emit_load(2'd1, vb);
    emit(`CPU_OP_OUT, 4'd1);
    emit(4'hC, 4'h5);
    emit(4'hD, 4'hA);
    emit(4'hE, 4'h3);
    emit(4'hF, 4'hF);
    emit(`CPU_OP_IN, 4'd3);
    emit(`CPU_OP_OUT, 4'd3);
    emit(`CPU_OP_OUT, 4'd7);
    run_program(vin);
    check_out(vb, "ignored opcodes after OUT 1");
    new_program();
    emit(`CPU_OP_OUT, 4'd0);  // A survives from the previous program
    run_program(8'h00);
    check_out(va, "register A after ignored opcodes");

    $display("Simulation passed");
    $finish;
  end

endmodule

/* hw/cpu_top.sv */
// Top level of the pipelined CPU
// Program memory, fetch, decode and execute

`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::host_ctrl_t    host_ctrl,
  input  logic [`CPU_DATA_W-1:0] data_in,
  output logic [`CPU_DATA_W-1:0] data_out
);

  import cpu_pkg::*;

  logic [`CPU_ADDR_W-1:0] rd_addr;
  logic [`CPU_DATA_W-1:0] rd_data;
  fetch_t                 fetch;
  ctrl_t                  ctrl;

  prog_mem u_prog_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_ctrl (host_ctrl),
    .data_in   (data_in),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  fetch_stage u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (host_ctrl.run),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .fetch   (fetch)
  );

  decode_stage u_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (fetch),
    .ctrl  (ctrl)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out)
  );

endmodule

/* hw/execute_stage.sv */
// Execute stage
// Registers A, B and C, write-back and the output register

`timescale 1ns/1ns
`include "cpu_defs.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_DATA_W-1:0] data_in,
  output logic [`CPU_DATA_W-1:0] data_out
);

  import cpu_pkg::*;

  localparam int NIB_W = `CPU_DATA_W - `CPU_OPC_W;

  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_b;
  logic [`CPU_DATA_W-1:0] reg_c;
  logic [`CPU_DATA_W-1:0] sel_val;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic [`CPU_DATA_W-1:0] wr_data;
  logic                   wr_en;
  logic                   out_en;

  alu u_alu (
    .a      (reg_a),
    .b      (reg_b),
    .alu_op (ctrl.alu_op),
    .result (alu_result)
  );

  //////////////////////////////////////////////////
  // Register read and write-back data
  //////////////////////////////////////////////////

  always_comb begin
    case (ctrl.reg_sel)
      sel_a:   sel_val = reg_a;
      sel_b:   sel_val = reg_b;
      sel_c:   sel_val = reg_c;
      default: sel_val = '0;
    endcase
  end

  always_comb begin
    wr_en   = ctrl.valid;
    wr_data = sel_val;
    case (ctrl.op)
      ex_load_lo: wr_data = {sel_val[`CPU_DATA_W-1:NIB_W], ctrl.operand};
      ex_load_hi: wr_data = {ctrl.operand, sel_val[NIB_W-1:0]};
      ex_alu:     wr_data = alu_result;  // Decode routes this to C
      ex_in:      wr_data = data_in;
      default:    wr_en   = 1'b0;
    endcase
  end

  assign out_en = ctrl.valid && (ctrl.op == ex_out) && (ctrl.reg_sel != sel_none);

  //////////////////////////////////////////////////
  // Register file and output
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else if (wr_en) begin
      case (ctrl.reg_sel)
        sel_a:   reg_a <= wr_data;
        sel_b:   reg_b <= wr_data;
        sel_c:   reg_c <= wr_data;
        default: ;  // Select none writes nothing
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out <= '0;
    end else if (out_en) begin
      data_out <= sel_val;
    end
  end

  // Output only moves after a valid OUT reached this stage
  a_out_only_on_out: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(data_out) |-> $past(ctrl.valid && ctrl.op == ex_out));

endmodule

/* hw/alu.sv */
// Combinational ALU
// Add, subtract and multiply, low byte kept

`timescale 1ns/1ns
`include "cpu_defs.svh"

module alu (
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  cpu_pkg::alu_op_e       alu_op,
  output logic [`CPU_DATA_W-1:0] result
);

  import cpu_pkg::*;

  // Each result truncates to the data width
  always_comb begin
    case (alu_op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_mul: result = a * b;
      default: result = '0;
    endcase
  end

endmodule

/* hw/decode_stage.sv */
// Decode stage
// Opcode to execute operation, ALU op and register select

`timescale 1ns/1ns
`include "cpu_defs.svh"

module decode_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  cpu_pkg::fetch_t fetch,
  output cpu_pkg::ctrl_t  ctrl
);

  import cpu_pkg::*;

  opcode_e  opc;
  ctrl_t    dec;
  reg_sel_e operand_sel;

  assign opc = opcode_e'(fetch.instr[`CPU_DATA_W-1:`CPU_DATA_W-`CPU_OPC_W]);

  // IN and OUT pick their register from the operand, 3 and up is none
  assign operand_sel = (fetch.instr[`CPU_OPC_W-1:0] < 3) ?
                       reg_sel_e'(fetch.instr[1:0]) : sel_none;

  always_comb begin
    dec         = '0;
    dec.valid   = fetch.valid;
    dec.op      = ex_none;
    dec.alu_op  = alu_add;
    dec.reg_sel = sel_none;
    dec.operand = fetch.instr[`CPU_OPC_W-1:0];
    case (opc)
      opc_ldal: begin dec.op = ex_load_lo; dec.reg_sel = sel_a; end
      opc_ldah: begin dec.op = ex_load_hi; dec.reg_sel = sel_a; end
      opc_ldbl: begin dec.op = ex_load_lo; dec.reg_sel = sel_b; end
      opc_ldbh: begin dec.op = ex_load_hi; dec.reg_sel = sel_b; end
      opc_ldcl: begin dec.op = ex_load_lo; dec.reg_sel = sel_c; end
      opc_ldch: begin dec.op = ex_load_hi; dec.reg_sel = sel_c; end
      opc_add:  begin dec.op = ex_alu; dec.alu_op = alu_add; dec.reg_sel = sel_c; end
      opc_sub:  begin dec.op = ex_alu; dec.alu_op = alu_sub; dec.reg_sel = sel_c; end
      opc_mul:  begin dec.op = ex_alu; dec.alu_op = alu_mul; dec.reg_sel = sel_c; end
      opc_out:  begin dec.op = ex_out; dec.reg_sel = operand_sel; end
      opc_in:   begin dec.op = ex_in; dec.reg_sel = operand_sel; end
      default:  dec.op = ex_none;  // NOP and 0xC to 0xF
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl.valid <= 1'b0;
    end else begin
      ctrl.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    ctrl.op      <= dec.op;
    ctrl.alu_op  <= dec.alu_op;
    ctrl.reg_sel <= dec.reg_sel;
    ctrl.operand <= dec.operand;
  end

  a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.valid == $past(fetch.valid));

endmodule

/* hw/fetch_stage.sv */
// Fetch stage
// Program counter and instruction register

`timescale 1ns/1ns
`include "cpu_defs.svh"

module fetch_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  output logic [`CPU_ADDR_W-1:0] rd_addr,
  input  logic [`CPU_DATA_W-1:0] rd_data,
  output cpu_pkg::fetch_t        fetch
);

  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] pc_next;
  logic                   valid_q;
  logic [`CPU_DATA_W-1:0] instr_q;

  assign pc_next = pc + 1'b1;  // Wraps so the program loops
  assign rd_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= run;  // Invalid while halted
      if (run) pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    instr_q <= rd_data;
  end

  assign fetch = '{valid: valid_q, instr: instr_q};

  // One step per running edge, wrapping at the memory depth
  a_pc_advance: assert property (@(posedge clk) disable iff (!rst_n)
    run |=> int'(pc) == (int'($past(pc)) + 1) % `CPU_MEM_DEPTH);

endmodule

/* hw/prog_mem.sv */
// Program memory, 16 bytes
// Host write port while stopped, asynchronous read for fetch

`timescale 1ns/1ns
`include "cpu_defs.svh"

module prog_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_pkg::host_ctrl_t    host_ctrl,
  input  logic [`CPU_DATA_W-1:0] data_in,
  input  logic [`CPU_ADDR_W-1:0] rd_addr,
  output logic [`CPU_DATA_W-1:0] rd_data
);

  logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

  // Cleared to all NOP on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (host_ctrl.load && !host_ctrl.run) begin
      mem[host_ctrl.addr] <= data_in;
    end
  end

  assign rd_data = mem[rd_addr];  // Combinational read

  // Host must not load while the program runs
  a_no_load_while_run: assert property (@(posedge clk) disable iff (!rst_n)
    !(host_ctrl.load && host_ctrl.run));

endmodule

/* hw/cpu_pkg.sv */
// Shared types of the CPU pipeline
// Opcode, execute and ALU encodings, host and stage bundles

`include "cpu_defs.svh"

package cpu_pkg;

  typedef enum logic [`CPU_OPC_W-1:0] {
    opc_nop  = `CPU_OP_NOP,
    opc_ldal = `CPU_OP_LDAL,
    opc_ldah = `CPU_OP_LDAH,
    opc_ldbl = `CPU_OP_LDBL,
    opc_ldbh = `CPU_OP_LDBH,
    opc_ldcl = `CPU_OP_LDCL,
    opc_ldch = `CPU_OP_LDCH,
    opc_add  = `CPU_OP_ADD,
    opc_sub  = `CPU_OP_SUB,
    opc_mul  = `CPU_OP_MUL,
    opc_out  = `CPU_OP_OUT,
    opc_in   = `CPU_OP_IN
  } opcode_e;

  typedef enum logic [2:0] {ex_none, ex_load_lo, ex_load_hi, ex_alu, ex_in, ex_out} exec_op_e;

  typedef enum logic [1:0] {alu_add, alu_sub, alu_mul} alu_op_e;

  typedef enum logic [1:0] {sel_a, sel_b, sel_c, sel_none} reg_sel_e;

  typedef struct packed {
    logic                   run;   // CPU executes
    logic                   load;  // Host writes program memory
    logic [`CPU_ADDR_W-1:0] addr;
  } host_ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic [`CPU_DATA_W-1:0] instr;
  } fetch_t;

  typedef struct packed {
    logic                              valid;
    exec_op_e                          op;
    alu_op_e                           alu_op;
    reg_sel_e                          reg_sel;
    logic [`CPU_DATA_W-`CPU_OPC_W-1:0] operand;  // Immediate nibble
  } ctrl_t;

endpackage

/* include/cpu_defs.svh */
// Widths and depth of the accumulator CPU
// Opcode encodings of the upper instruction nibble

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_DATA_W     8   // Register and data bus width
`define CPU_ADDR_W     4   // Program counter width
`define CPU_MEM_DEPTH  16  // Program bytes
`define CPU_OPC_W      4   // Opcode field width

`define CPU_OP_NOP   4'd0
`define CPU_OP_LDAL  4'd1
`define CPU_OP_LDAH  4'd2
`define CPU_OP_LDBL  4'd3
`define CPU_OP_LDBH  4'd4
`define CPU_OP_LDCL  4'd5
`define CPU_OP_LDCH  4'd6
`define CPU_OP_ADD   4'd7
`define CPU_OP_SUB   4'd8
`define CPU_OP_MUL   4'd9
`define CPU_OP_OUT   4'd10
`define CPU_OP_IN    4'd11

`endif
